// ==== bus_decode.sv ====
////////////////////////////////////////
// Address decoder of the internal bus. Strobes
// one slave and returns its read data a cycle later
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module bus_decode (
   input  wire                      dsp_clk,
   input  wire                      reset_i,
   input  wire                      bus_stb_i,
   input  wire core_pkg::bus_addr_t bus_addr_i,
   input  wire core_pkg::bus_data_t set_rdata_i,
   input  wire core_pkg::bus_data_t irq_rdata_i,
   output logic                     set_stb_o,
   output logic                     irq_stb_o,
   output core_pkg::word_ofs_t      ofs_o,
   output logic                     bus_done_o,
   output logic                     bus_err_o,
   output core_pkg::bus_data_t      bus_rdata_o
);

   localparam int PAGE_LSB = core_pkg::REGION_LSB;
   localparam int PAGE_MSB = core_pkg::ADDR_W - 1;

   logic [PAGE_MSB-PAGE_LSB:0] page;
   core_pkg::slave_e           target;
   core_pkg::slave_e           target_q;

   assign page  = bus_addr_i[PAGE_MSB:PAGE_LSB];
   assign ofs_o = bus_addr_i[PAGE_LSB-1:2];

   always_comb begin
      if (page == core_pkg::SETTINGS_BASE[PAGE_MSB:PAGE_LSB]) begin
         target = core_pkg::SLV_SETTINGS;
      end else if (page == core_pkg::IRQ_BASE[PAGE_MSB:PAGE_LSB]) begin
         target = core_pkg::SLV_IRQ;
      end else begin
         target = core_pkg::SLV_NONE;
      end
   end

   assign set_stb_o = bus_stb_i && (target == core_pkg::SLV_SETTINGS);
   assign irq_stb_o = bus_stb_i && (target == core_pkg::SLV_IRQ);

   // Remember who was addressed for the data phase
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         bus_done_o <= 1'b0;
         target_q   <= core_pkg::SLV_NONE;
      end else begin
         bus_done_o <= bus_stb_i;
         if (bus_stb_i) begin
            target_q <= target;
         end
      end
   end

   always_comb begin
      case (target_q)
         core_pkg::SLV_SETTINGS: bus_rdata_o = set_rdata_i;
         core_pkg::SLV_IRQ:      bus_rdata_o = irq_rdata_i;
         default:                bus_rdata_o = '0;
      endcase
   end

   assign bus_err_o = bus_done_o && (target_q == core_pkg::SLV_NONE);

   a_one_slave: assert property (@(posedge dsp_clk) disable iff (reset_i)
      !(set_stb_o && irq_stb_o));

endmodule

`default_nettype wire

// ==== bus_port.sv ====
////////////////////////////////////////
// Host port. Converts a four-phase req/ack
// transaction into one internal bus strobe
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module bus_port (
   input  wire                      dsp_clk,
   input  wire                      reset_i,
   // Host side
   input  wire                      req_i,
   input  wire                      we_i,
   input  wire core_pkg::bus_addr_t addr_i,
   input  wire core_pkg::bus_data_t wdata_i,
   output logic                     ack_o,
   output logic                     err_o,
   output core_pkg::bus_data_t      rdata_o,
   // Internal bus side
   input  wire                      bus_done_i,
   input  wire                      bus_err_i,
   input  wire core_pkg::bus_data_t bus_rdata_i,
   output logic                     bus_stb_o,
   output logic                     bus_we_o,
   output core_pkg::bus_addr_t      bus_addr_o,
   output core_pkg::bus_data_t      bus_wdata_o
);

   core_pkg::port_state_e state;

   ////////////////////////////////////////
   // Handshake FSM
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         state     <= core_pkg::PS_IDLE;
         bus_stb_o <= 1'b0;
         ack_o     <= 1'b0;
         err_o     <= 1'b0;
      end else begin
         bus_stb_o <= 1'b0;
         case (state)
            core_pkg::PS_IDLE: begin
               if (req_i) begin
                  state <= core_pkg::PS_ISSUE;
               end
            end
            core_pkg::PS_ISSUE: begin
               // Launch the strobe with the latched request
               bus_stb_o <= 1'b1;
               state     <= core_pkg::PS_WAIT;
            end
            core_pkg::PS_WAIT: begin
               if (bus_done_i) begin
                  ack_o <= 1'b1;
                  err_o <= bus_err_i;
                  state <= core_pkg::PS_HOLD;
               end
            end
            core_pkg::PS_HOLD: begin
               // Host holds req high as long as it likes
               if (!req_i) begin
                  ack_o <= 1'b0;
                  err_o <= 1'b0;
                  state <= core_pkg::PS_IDLE;
               end
            end
            default: state <= core_pkg::PS_IDLE;
         endcase
      end
   end

   // Request capture and read data return
   always_ff @(posedge dsp_clk) begin
      if (state == core_pkg::PS_IDLE && req_i) begin
         bus_we_o    <= we_i;
         bus_addr_o  <= addr_i;
         bus_wdata_o <= wdata_i;
      end
      if (state == core_pkg::PS_WAIT && bus_done_i) begin
         rdata_o <= bus_rdata_i;
      end
   end

   a_no_ack_in_idle: assert property (@(posedge dsp_clk) disable iff (reset_i)
      state == core_pkg::PS_IDLE |-> !ack_o);

   a_single_strobe: assert property (@(posedge dsp_clk) disable iff (reset_i)
      bus_stb_o |=> !bus_stb_o);

endmodule

`default_nettype wire

// ==== core_pkg.sv ====
////////////////////////////////////////
// Internal bus widths, types and region map
// shared by the port, the decoder and the slaves
////////////////////////////////////////
`default_nettype none

package core_pkg;

   localparam int ADDR_W = 16;
   localparam int DATA_W = 32;
   localparam int OFS_W  = 6;

   // Slave regions are 256 bytes each
   localparam int REGION_LSB = 8;

   typedef logic [ADDR_W-1:0] bus_addr_t;
   typedef logic [DATA_W-1:0] bus_data_t;
   typedef logic [OFS_W-1:0]  word_ofs_t;

   localparam bus_addr_t SETTINGS_BASE = 16'h0000;
   localparam bus_addr_t IRQ_BASE      = 16'h0100;

   // Decoded bus targets
   typedef enum logic [1:0] {SLV_SETTINGS, SLV_IRQ, SLV_NONE} slave_e;

   // Host port handshake states
   typedef enum logic [1:0] {PS_IDLE, PS_ISSUE, PS_WAIT, PS_HOLD} port_state_e;

endpackage

`default_nettype wire

// ==== ctrl_pkg.sv ====
////////////////////////////////////////
// Register map and field types of the
// settings bank and the interrupt controller
////////////////////////////////////////
`default_nettype none

package ctrl_pkg;

   // Field widths
   localparam int CLOCK_W  = 5;
   localparam int SERDES_W = 4;
   localparam int ADC_W    = 4;
   localparam int LED_W    = 8;
   localparam int CLKDIV_W = 4;

   typedef logic [CLOCK_W-1:0]  clock_ctl_t;
   typedef logic [SERDES_W-1:0] serdes_ctl_t;
   typedef logic [ADC_W-1:0]    adc_ctl_t;
   typedef logic [LED_W-1:0]    led_t;
   typedef logic [CLKDIV_W-1:0] clkdiv_t;

   ////////////////////////////////////////
   // Settings word offsets
   localparam core_pkg::word_ofs_t SR_CLOCK   = 6'd0;
   localparam core_pkg::word_ofs_t SR_SERDES  = 6'd1;
   localparam core_pkg::word_ofs_t SR_ADC     = 6'd2;
   localparam core_pkg::word_ofs_t SR_LED_SW  = 6'd3;
   localparam core_pkg::word_ofs_t SR_PHY     = 6'd4;
   localparam core_pkg::word_ofs_t SR_LED_SRC = 6'd8;
   localparam core_pkg::word_ofs_t SR_STATUS  = 6'd9;

   // Status word bit positions with the divider in the low bits
   localparam int ST_SIM_MODE   = 31;
   localparam int ST_CLK_STATUS = 5;
   localparam int ST_LINK_UP    = 4;

   // Hardware LED sources
   localparam int LED_HW_LINK = 0;
   localparam int LED_HW_CLK  = 1;

   ////////////////////////////////////////
   // Interrupt controller word offsets
   localparam core_pkg::word_ofs_t IRQ_PENDING = 6'd0;
   localparam core_pkg::word_ofs_t IRQ_MASK    = 6'd1;

endpackage

`default_nettype wire

// ==== irq_ctrl.sv ====
////////////////////////////////////////
// Edge triggered interrupt controller with
// write-one-to-clear pending and a mask word
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module irq_ctrl #(
   parameter int NUM_IRQ = 16
) (
   input  wire                      dsp_clk,
   input  wire                      reset_i,
   input  wire                      stb_i,
   input  wire                      we_i,
   input  wire core_pkg::word_ofs_t ofs_i,
   input  wire core_pkg::bus_data_t wdata_i,
   input  wire [NUM_IRQ-1:0]        irq_src_i,
   output core_pkg::bus_data_t      rdata_o,
   output logic                     int_o
);

   logic [NUM_IRQ-1:0] src_q;
   logic [NUM_IRQ-1:0] src_d;
   logic [NUM_IRQ-1:0] rise;
   logic [NUM_IRQ-1:0] clr;
   logic [NUM_IRQ-1:0] pend_q;
   logic [NUM_IRQ-1:0] mask_q;

   // A rise is a new high sample over an old low one
   assign rise = src_q & ~src_d;
   assign clr  = (stb_i && we_i && ofs_i == ctrl_pkg::IRQ_PENDING) ?
                 wdata_i[NUM_IRQ-1:0] : '0;

   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         src_q  <= '0;
         src_d  <= '0;
         pend_q <= '0;
         mask_q <= '0;
      end else begin
         src_q  <= irq_src_i;
         src_d  <= src_q;
         // New edges win over a clear in the same cycle
         pend_q <= (pend_q & ~clr) | rise;
         if (stb_i && we_i && ofs_i == ctrl_pkg::IRQ_MASK) begin
            mask_q <= wdata_i[NUM_IRQ-1:0];
         end
      end
   end

   always_ff @(posedge dsp_clk) begin
      if (stb_i) begin
         case (ofs_i)
            ctrl_pkg::IRQ_PENDING: rdata_o <= core_pkg::bus_data_t'(pend_q);
            ctrl_pkg::IRQ_MASK:    rdata_o <= core_pkg::bus_data_t'(mask_q);
            default:               rdata_o <= '0;
         endcase
      end
   end

   assign int_o = |(pend_q & mask_q);

   ////////////////////////////////////////
   // A pending bit only rises after a source edge
   for (genvar i = 0; i < NUM_IRQ; i++) begin : g_pend_chk
      a_pend_from_edge: assert property (@(posedge dsp_clk) disable iff (reset_i)
         $rose(pend_q[i]) |-> $past(irq_src_i[i], 2) && !$past(irq_src_i[i], 3));
   end

endmodule

`default_nettype wire

// ==== settings_bank.sv ====
////////////////////////////////////////
// Settings registers with their control pins,
// LED source select and the read-only status word
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module settings_bank (
   input  wire                        dsp_clk,
   input  wire                        reset_i,
   input  wire                        stb_i,
   input  wire                        we_i,
   input  wire core_pkg::word_ofs_t   ofs_i,
   input  wire core_pkg::bus_data_t   wdata_i,
   input  wire                        clk_status_i,
   input  wire                        serdes_link_up_i,
   input  wire                        sim_mode_i,
   input  wire ctrl_pkg::clkdiv_t     clock_divider_i,
   output core_pkg::bus_data_t        rdata_o,
   output ctrl_pkg::clock_ctl_t       clock_ctl_o,
   output ctrl_pkg::serdes_ctl_t      serdes_ctl_o,
   output ctrl_pkg::adc_ctl_t         adc_ctl_o,
   output logic                       phy_reset_o,
   output ctrl_pkg::led_t             leds_o
);

   ctrl_pkg::led_t      led_sw;
   ctrl_pkg::led_t      led_src;
   ctrl_pkg::led_t      led_hw;
   core_pkg::bus_data_t status;

   ////////////////////////////////////////
   // Register writes
   always_ff @(posedge dsp_clk) begin
      if (reset_i) begin
         clock_ctl_o  <= '0;
         serdes_ctl_o <= '0;
         adc_ctl_o    <= '0;
         phy_reset_o  <= 1'b0;
         led_sw       <= '0;
         led_src      <= '0;
      end else if (stb_i && we_i) begin
         case (ofs_i)
            ctrl_pkg::SR_CLOCK:   clock_ctl_o  <= wdata_i[ctrl_pkg::CLOCK_W-1:0];
            ctrl_pkg::SR_SERDES:  serdes_ctl_o <= wdata_i[ctrl_pkg::SERDES_W-1:0];
            ctrl_pkg::SR_ADC:     adc_ctl_o    <= wdata_i[ctrl_pkg::ADC_W-1:0];
            ctrl_pkg::SR_LED_SW:  led_sw       <= wdata_i[ctrl_pkg::LED_W-1:0];
            ctrl_pkg::SR_PHY:     phy_reset_o  <= wdata_i[0];
            ctrl_pkg::SR_LED_SRC: led_src      <= wdata_i[ctrl_pkg::LED_W-1:0];
            // Status and unused offsets ignore writes
            default: ;
         endcase
      end
   end

   // Status word
   always_comb begin
      status = '0;
      status[ctrl_pkg::ST_SIM_MODE]   = sim_mode_i;
      status[ctrl_pkg::ST_CLK_STATUS] = clk_status_i;
      status[ctrl_pkg::ST_LINK_UP]    = serdes_link_up_i;
      status[ctrl_pkg::CLKDIV_W-1:0]  = clock_divider_i;
   end

   // Read data registered on the strobe
   always_ff @(posedge dsp_clk) begin
      if (stb_i) begin
         case (ofs_i)
            ctrl_pkg::SR_CLOCK:   rdata_o <= core_pkg::bus_data_t'(clock_ctl_o);
            ctrl_pkg::SR_SERDES:  rdata_o <= core_pkg::bus_data_t'(serdes_ctl_o);
            ctrl_pkg::SR_ADC:     rdata_o <= core_pkg::bus_data_t'(adc_ctl_o);
            ctrl_pkg::SR_LED_SW:  rdata_o <= core_pkg::bus_data_t'(led_sw);
            ctrl_pkg::SR_PHY:     rdata_o <= core_pkg::bus_data_t'(phy_reset_o);
            ctrl_pkg::SR_LED_SRC: rdata_o <= core_pkg::bus_data_t'(led_src);
            ctrl_pkg::SR_STATUS:  rdata_o <= status;
            default:              rdata_o <= '0;
         endcase
      end
   end

   ////////////////////////////////////////
   // LEDs where a source bit of 1 selects hardware
   always_comb begin
      led_hw = '0;
      led_hw[ctrl_pkg::LED_HW_LINK] = serdes_link_up_i;
      led_hw[ctrl_pkg::LED_HW_CLK]  = clk_status_i;
   end

   assign leds_o = (led_src & led_hw) | (~led_src & led_sw);

endmodule

`default_nettype wire

// ==== tb_tasks.svh ====
////////////////////////////////////////
// Host bus access, compare and directed test
// tasks, included inside the testbench top
////////////////////////////////////////
`default_nettype none

function automatic core_pkg::bus_addr_t word_addr(input core_pkg::bus_addr_t base,
                                                  input core_pkg::word_ofs_t ofs);
   return base + {8'h00, ofs, 2'b00};
endfunction

task automatic cmp_data(input string name, input core_pkg::bus_data_t got,
                        input core_pkg::bus_data_t exp);
   if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
   end
endtask

task automatic cmp_led(input string name, input ctrl_pkg::led_t got,
                       input ctrl_pkg::led_t exp);
   if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
   end
endtask

task automatic cmp_bit(input string name, input logic got, input logic exp);
   if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
   end
endtask

task automatic cmp_clock(input string name, input ctrl_pkg::clock_ctl_t got,
                         input ctrl_pkg::clock_ctl_t exp);
   if (got !== exp) begin
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, exp);
      abort_run();
   end
endtask

////////////////////////////////////////
// Four-phase host transaction
task automatic bus_access(input logic we, input core_pkg::bus_addr_t addr,
                          input core_pkg::bus_data_t data,
                          output core_pkg::bus_data_t rdata, output logic err);
   @(negedge dsp_clk);
   if (ack_o !== 1'b0) begin
      $display("Host port still acknowledges when a new request starts");
      abort_run();
   end
   req_i   = 1'b1;
   we_i    = we;
   addr_i  = addr;
   wdata_i = data;
   do begin
      @(negedge dsp_clk);
   end while (ack_o !== 1'b1);
   rdata = rdata_o;
   err   = err_o;
   req_i = 1'b0;
   do begin
      @(negedge dsp_clk);
   end while (ack_o !== 1'b0);
endtask

task automatic bus_write(input core_pkg::bus_addr_t addr, input core_pkg::bus_data_t data);
   core_pkg::bus_data_t rd;
   logic                err;
   bus_access(1'b1, addr, data, rd, err);
   cmp_bit("err_o", err, 1'b0);
endtask

task automatic bus_read(input core_pkg::bus_addr_t addr, output core_pkg::bus_data_t data);
   logic err;
   bus_access(1'b0, addr, '0, data, err);
   cmp_bit("err_o", err, 1'b0);
endtask

////////////////////////////////////////
// Directed tests
task automatic test_reset_values();
   cmp_bit("ack_o", ack_o, 1'b0);
   cmp_bit("err_o", err_o, 1'b0);
   cmp_bit("int_o", int_o, 1'b0);
   cmp_bit("phy_reset_o", phy_reset_o, 1'b0);
   cmp_clock("clock_ctl_o", clock_ctl_o, '0);
   cmp_data("serdes_ctl_o", core_pkg::bus_data_t'(serdes_ctl_o), '0);
   cmp_data("adc_ctl_o", core_pkg::bus_data_t'(adc_ctl_o), '0);
   cmp_led("leds_o", leds_o, '0);
endtask

task automatic test_settings_writes();
   core_pkg::bus_data_t clk_v;
   core_pkg::bus_data_t ser_v;
   core_pkg::bus_data_t adc_v;
   core_pkg::bus_data_t phy_v;
   core_pkg::bus_data_t rd;
   repeat (3) begin
      clk_v = $urandom;
      ser_v = $urandom;
      adc_v = $urandom;
      phy_v = $urandom;
      bus_write(word_addr(core_pkg::SETTINGS_BASE, ctrl_pkg::SR_CLOCK), clk_v);
      bus_write(word_addr(core_pkg::SETTINGS_BASE, ctrl_pkg::SR_SERDES), ser_v);
      bus_write(word_addr(core_pkg::SETTINGS_BASE, ctrl_pkg::SR_ADC), adc_v);
      bus_write(word_addr(core_pkg::SETTINGS_BASE, ctrl_pkg::SR_PHY), phy_v);
      cmp_clock("clock_ctl_o", clock_ctl_o, clk_v[4:0]);
      cmp_data("serdes_ctl_o", core_pkg::bus_data_t'(serdes_ctl_o), {28'd0, ser_v[3:0]});
      cmp_data("adc_ctl_o", core_pkg::bus_data_t'(adc_ctl_o), {28'd0, adc_v[3:0]});
      cmp_bit("phy_reset_o", phy_reset_o, phy_v[0]);
      bus_read(word_addr(core_pkg::SETTINGS_BASE, ctrl_pkg::SR_CLOCK), rd);
      cmp_data("SR_CLOCK read", rd, {27'd0, clk_v[4:0]});
      bus_read(word_addr(core_pkg::SETTINGS_BASE, ctrl_pkg::SR_SERDES), rd);
      cmp_data("SR_SERDES read", rd, {28'd0, ser_v[3:0]});
      bus_read(word_addr(core_pkg::SETTINGS_BASE, ctrl_pkg::SR_ADC), rd);
      cmp_data("SR_ADC read", rd, {28'd0, adc_v[3:0]});
      bus_read(word_addr(core_pkg::SETTINGS_BASE, ctrl_pkg::SR_PHY), rd);
      cmp_data("SR_PHY read", rd, {31'd0, phy_v[0]});
   end
endtask

task automatic test_led_select();
   core_pkg::bus_data_t rnd;
   ctrl_pkg::led_t      sw;
   ctrl_pkg::led_t      src;
   ctrl_pkg::led_t      exp;
   int                  i;
   repeat (4) begin
      rnd = $urandom;
      sw  = rnd[7:0];
      src = rnd[15:8];
      bus_write(word_addr(core_pkg::SETTINGS_BASE, ctrl_pkg::SR_LED_SW), {24'd0, sw});
      bus_write(word_addr(core_pkg::SETTINGS_BASE, ctrl_pkg::SR_LED_SRC), {24'd0, src});
      clk_status_i     = rnd[16];
      serdes_link_up_i = rnd[17];
      @(negedge dsp_clk);
      // Hardware LEDs are link up on bit 0 and clock status on bit 1
      for (i = 0; i < 8; i++) begin
         if (!src[i]) begin
            exp[i] = sw[i];
         end else if (i == 0) begin
            exp[i] = serdes_link_up_i;
         end else if (i == 1) begin
            exp[i] = clk_status_i;
         end else begin
            exp[i] = 1'b0;
         end
      end
      cmp_led("leds_o", leds_o, exp);
   end
endtask

task automatic test_status_word();
   core_pkg::bus_data_t rnd;
   core_pkg::bus_data_t exp;
   core_pkg::bus_data_t rd;
   repeat (4) begin
      rnd = $urandom;
      sim_mode_i       = rnd[0];
      clk_status_i     = rnd[1];
      serdes_link_up_i = rnd[2];
      clock_divider_i  = rnd[7:4];
      exp     = '0;
      exp[31] = sim_mode_i;
      exp[5]  = clk_status_i;
      exp[4]  = serdes_link_up_i;
      exp[3:0] = clock_divider_i;
      bus_read(word_addr(core_pkg::SETTINGS_BASE, ctrl_pkg::SR_STATUS), rd);
      cmp_data("SR_STATUS read", rd, exp);
   end
endtask

task automatic test_interrupts();
   int                  idx;
   core_pkg::bus_data_t bit_sel;
   core_pkg::bus_data_t rd;
   idx     = $urandom % NUM_IRQ;
   bit_sel = 32'd1 << idx;
   irq_src_i[idx] = 1'b1;
   // Edge detector delay plus the pending register
   repeat (3) @(negedge dsp_clk);
   bus_read(word_addr(core_pkg::IRQ_BASE, ctrl_pkg::IRQ_PENDING), rd);
   cmp_data("IRQ_PENDING read", rd, bit_sel);
   cmp_bit("int_o", int_o, 1'b0);
   bus_write(word_addr(core_pkg::IRQ_BASE, ctrl_pkg::IRQ_MASK), bit_sel);
   cmp_bit("int_o", int_o, 1'b1);
   bus_read(word_addr(core_pkg::IRQ_BASE, ctrl_pkg::IRQ_MASK), rd);
   cmp_data("IRQ_MASK read", rd, bit_sel);
   // Write one to clear
   bus_write(word_addr(core_pkg::IRQ_BASE, ctrl_pkg::IRQ_PENDING), bit_sel);
   cmp_bit("int_o", int_o, 1'b0);
   bus_read(word_addr(core_pkg::IRQ_BASE, ctrl_pkg::IRQ_PENDING), rd);
   cmp_data("IRQ_PENDING read", rd, '0);
   irq_src_i = '0;
endtask

task automatic test_unmapped();
   core_pkg::bus_data_t rd;
   logic                err;
   bus_access(1'b0, 16'h0800, '0, rd, err);
   cmp_bit("err_o", err, 1'b1);
   cmp_data("unmapped read", rd, '0);
   bus_access(1'b1, 16'h0800, 32'hffff_ffff, rd, err);
   cmp_bit("err_o", err, 1'b1);
   // Unused settings offset
   bus_read(word_addr(core_pkg::SETTINGS_BASE, 6'd5), rd);
   cmp_data("unused settings read", rd, '0);
endtask

`default_nettype wire

// ==== tb_top.sv ====
////////////////////////////////////////
// Testbench of the control plane top level.
// Directed tests driven on the falling clock edge
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module tb_top;

   localparam int NUM_IRQ = 16;
   // About 40 host accesses of under 10 cycles each plus a wide margin
   localparam int TIMEOUT_CYCLES = 2000;

   logic                  dsp_clk;
   logic                  reset_i;
   logic                  req_i;
   logic                  we_i;
   core_pkg::bus_addr_t   addr_i;
   core_pkg::bus_data_t   wdata_i;
   logic                  ack_o;
   logic                  err_o;
   core_pkg::bus_data_t   rdata_o;
   logic                  clk_status_i;
   logic                  serdes_link_up_i;
   logic                  sim_mode_i;
   ctrl_pkg::clkdiv_t     clock_divider_i;
   logic [NUM_IRQ-1:0]    irq_src_i;
   ctrl_pkg::clock_ctl_t  clock_ctl_o;
   ctrl_pkg::serdes_ctl_t serdes_ctl_o;
   ctrl_pkg::adc_ctl_t    adc_ctl_o;
   logic                  phy_reset_o;
   ctrl_pkg::led_t        leds_o;
   logic                  int_o;

   int cycle_count = 0;
   int seed_value;

   u2_ctrl_top #(.NUM_IRQ(NUM_IRQ)) u_dut (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .req_i(req_i), .we_i(we_i), .addr_i(addr_i), .wdata_i(wdata_i),
      .ack_o(ack_o), .err_o(err_o), .rdata_o(rdata_o),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i),
      .irq_src_i(irq_src_i),
      .clock_ctl_o(clock_ctl_o), .serdes_ctl_o(serdes_ctl_o), .adc_ctl_o(adc_ctl_o),
      .phy_reset_o(phy_reset_o), .leds_o(leds_o), .int_o(int_o)
   );

   // 20 ns clock
   initial begin
      dsp_clk = 1'b0;
      forever #10 dsp_clk = ~dsp_clk;
   end

   task automatic abort_run();
      $display("TB FAILED");
      $fatal(1);
   endtask

   ////////////////////////////////////////
   // Timeout watchdog
   always @(posedge dsp_clk) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= TIMEOUT_CYCLES) begin
         $display("Timeout, the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
         abort_run();
      end
   end

   `include "tb_tasks.svh"

   ////////////////////////////////////////
   // Test sequence
   initial begin
      seed_value       = $urandom(32'h8b50_895e);
      reset_i          = 1'b1;
      req_i            = 1'b0;
      we_i             = 1'b0;
      addr_i           = '0;
      wdata_i          = '0;
      clk_status_i     = 1'b0;
      serdes_link_up_i = 1'b0;
      sim_mode_i       = 1'b0;
      clock_divider_i  = '0;
      irq_src_i        = '0;
      // Eight rising edges in reset
      repeat (8) @(posedge dsp_clk);
      @(negedge dsp_clk);
      reset_i = 1'b0;
      @(negedge dsp_clk);
      test_reset_values();
      test_settings_writes();
      test_led_select();
      test_status_word();
      test_interrupts();
      test_unmapped();
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== u2_ctrl_top.sv ====
////////////////////////////////////////
// Control plane top. Host port, decoder,
// settings bank and interrupt controller
////////////////////////////////////////
`default_nettype none
`timescale 1ns/1ns

module u2_ctrl_top #(
   parameter int NUM_IRQ = 16
) (
   input  wire                       dsp_clk,
   input  wire                       reset_i,
   // Host port
   input  wire                       req_i,
   input  wire                       we_i,
   input  wire core_pkg::bus_addr_t  addr_i,
   input  wire core_pkg::bus_data_t  wdata_i,
   output logic                      ack_o,
   output logic                      err_o,
   output core_pkg::bus_data_t       rdata_o,
   // Board status
   input  wire                       clk_status_i,
   input  wire                       serdes_link_up_i,
   input  wire                       sim_mode_i,
   input  wire ctrl_pkg::clkdiv_t    clock_divider_i,
   input  wire [NUM_IRQ-1:0]         irq_src_i,
   // Control pins
   output ctrl_pkg::clock_ctl_t      clock_ctl_o,
   output ctrl_pkg::serdes_ctl_t     serdes_ctl_o,
   output ctrl_pkg::adc_ctl_t        adc_ctl_o,
   output logic                      phy_reset_o,
   output ctrl_pkg::led_t            leds_o,
   output logic                      int_o
);

   logic                bus_stb;
   logic                bus_we;
   core_pkg::bus_addr_t bus_addr;
   core_pkg::bus_data_t bus_wdata;
   logic                bus_done;
   logic                bus_err;
   core_pkg::bus_data_t bus_rdata;
   logic                set_stb;
   logic                irq_stb;
   core_pkg::word_ofs_t ofs;
   core_pkg::bus_data_t set_rdata;
   core_pkg::bus_data_t irq_rdata;

   bus_port u_port (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .req_i(req_i), .we_i(we_i), .addr_i(addr_i), .wdata_i(wdata_i),
      .ack_o(ack_o), .err_o(err_o), .rdata_o(rdata_o),
      .bus_done_i(bus_done), .bus_err_i(bus_err), .bus_rdata_i(bus_rdata),
      .bus_stb_o(bus_stb), .bus_we_o(bus_we), .bus_addr_o(bus_addr),
      .bus_wdata_o(bus_wdata)
   );

   bus_decode u_decode (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .bus_stb_i(bus_stb), .bus_addr_i(bus_addr),
      .set_rdata_i(set_rdata), .irq_rdata_i(irq_rdata),
      .set_stb_o(set_stb), .irq_stb_o(irq_stb), .ofs_o(ofs),
      .bus_done_o(bus_done), .bus_err_o(bus_err), .bus_rdata_o(bus_rdata)
   );

   settings_bank u_settings (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .stb_i(set_stb), .we_i(bus_we), .ofs_i(ofs), .wdata_i(bus_wdata),
      .clk_status_i(clk_status_i), .serdes_link_up_i(serdes_link_up_i),
      .sim_mode_i(sim_mode_i), .clock_divider_i(clock_divider_i),
      .rdata_o(set_rdata), .clock_ctl_o(clock_ctl_o), .serdes_ctl_o(serdes_ctl_o),
      .adc_ctl_o(adc_ctl_o), .phy_reset_o(phy_reset_o), .leds_o(leds_o)
   );

   irq_ctrl #(.NUM_IRQ(NUM_IRQ)) u_irq (
      .dsp_clk(dsp_clk), .reset_i(reset_i),
      .stb_i(irq_stb), .we_i(bus_we), .ofs_i(ofs), .wdata_i(bus_wdata),
      .irq_src_i(irq_src_i), .rdata_o(irq_rdata), .int_o(int_o)
   );

endmodule

`default_nettype wire

// ==== verilog.f ====
+incdir+.
core_pkg.sv
ctrl_pkg.sv
bus_port.sv
bus_decode.sv
settings_bank.sv
irq_ctrl.sv
u2_ctrl_top.sv
tb_top.sv
